// File: filelist.f
+incdir+include
rtl/store_pkg.sv
rtl/store_buffer_if.sv
rtl/mtime_timer.sv
rtl/store_buffer.sv
rtl/store_unit.sv
rtl/store_subsystem_top.sv
test/tb_clock_gen.sv
test/store_subsystem_tb.sv

// File: Makefile
TOP := store_subsystem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module store_subsystem_top
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" sim.log || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// File: test/store_subsystem_tb.sv
/*
 * Self-checking testbench for the store path with BUF_DEPTH 4 and a random memory responder.
 * Expected values come from a queue model of issued stores, random stream starts at seed 79.
 */
`timescale 1ns/1ns
`include "store_memory_map.svh"

module store_subsystem_tb
    import store_pkg::*;
();

    localparam int BUF_DEPTH   = 4;
    localparam int STORE_COUNT = 40;
    localparam int CYCLE_LIMIT = STORE_COUNT * 12 + 200;

    logic         clk_i;
    logic         rst_n_i;
    logic         valid_operation_i = 1'b0;
    data_word_t   store_address_i   = '0;
    data_word_t   store_data_i      = '0;
    store_width_t store_width_i     = STORE_WORD;
    logic         data_accepted_i   = 1'b0;
    logic         mem_done_i        = 1'b0;
    logic         idle_o;
    logic         illegal_access_o;
    logic         cachable_o;
    logic         data_valid_o;
    timer_word_t  timer_value_o;
    logic         mem_req_o;
    data_word_t   mem_address_o;
    data_word_t   mem_data_o;
    store_width_t mem_width_o;

    // Cachable stores in issue order, one direct store at most
    data_word_t   exp_addr_q[$];
    data_word_t   exp_data_q[$];
    store_width_t exp_width_q[$];
    logic         direct_pending = 1'b0;
    data_word_t   direct_addr    = '0;
    data_word_t   direct_data    = '0;
    store_width_t direct_width   = STORE_WORD;
    // Timer model is last written value plus one per two cycles since
    logic         timer_known    = 1'b0;
    timer_word_t  timer_base     = '0;
    timer_word_t  timer_age      = '0;

    integer       seed           = 79;
    logic         mem_stall      = 1'b0;
    logic         stall_check    = 1'b0;
    logic         reset_seen     = 1'b0;
    int unsigned  mem_delay      = 2;
    int unsigned  wait_count     = 0;
    int           cycle_count    = 0;
    int           mismatch_count = 0;
    int           failure_count  = 0;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (4)
    ) clock_gen_i (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    store_subsystem_top #(
        .BUF_DEPTH (BUF_DEPTH)
    ) dut_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .valid_operation_i (valid_operation_i),
        .store_address_i   (store_address_i),
        .store_data_i      (store_data_i),
        .store_width_i     (store_width_i),
        .data_accepted_i   (data_accepted_i),
        .idle_o            (idle_o),
        .illegal_access_o  (illegal_access_o),
        .cachable_o        (cachable_o),
        .data_valid_o      (data_valid_o),
        .timer_value_o     (timer_value_o),
        .mem_req_o         (mem_req_o),
        .mem_address_o     (mem_address_o),
        .mem_data_o        (mem_data_o),
        .mem_width_o       (mem_width_o),
        .mem_done_i        (mem_done_i)
    );

    function automatic data_word_t random_word();
        return $random(seed);
    endfunction

    // Region 0 is boot, 1 timer, 2 IO outside the timer, anything else cachable
    function automatic data_word_t region_address(input int region);
        data_word_t r;
        r = random_word();
        case (region)
            0: return r & (`BOOT_END - 32'd4);
            1: return `TIMER_START + (r & 32'h0000_000C);
            2: return `TIMER_END + ((r % (`IO_END - `TIMER_END)) & 32'hFFFF_FFFC);
            default: return `IO_END + (r & 32'h0FFF_FFFC);
        endcase
    endfunction

    task automatic compare_word(input string name, input data_word_t expected,
                                input data_word_t actual);
        assert (expected == actual) else begin
            mismatch_count++;
            $display("MISMATCH %s expected %h got %h", name, expected, actual);
        end
    endtask

    // ==================================================
    // Reference model
    // ==================================================

    // A write completes on the edge where mem_req_o meets mem_done_i
    task automatic check_write();
        if (mem_address_o >= `IO_END) begin
            if (exp_addr_q.size() == 0) begin
                failure_count++;
                $display("Cachable write to %h reached memory with no store pending",
                         mem_address_o);
            end else begin
                compare_word("mem_address_o", exp_addr_q.pop_front(), mem_address_o);
                compare_word("mem_data_o", exp_data_q.pop_front(), mem_data_o);
                compare_word("mem_width_o", data_word_t'(exp_width_q.pop_front()),
                             data_word_t'(mem_width_o));
            end
        end else if (direct_pending && mem_address_o == direct_addr) begin
            compare_word("mem_data_o", direct_data, mem_data_o);
            compare_word("mem_width_o", data_word_t'(direct_width), data_word_t'(mem_width_o));
            direct_pending <= 1'b0;
        end else begin
            failure_count++;
            $display("Write to %h reached memory but no such store was issued", mem_address_o);
        end
    endtask

    task automatic record_issue();
        compare_word("cachable_o", data_word_t'(store_address_i >= `IO_END),
                     data_word_t'(cachable_o));
        if (store_address_i < `BOOT_END) begin
            compare_word("illegal_access_o", 32'd1, data_word_t'(illegal_access_o));
        end else if (store_address_i >= `TIMER_START && store_address_i < `TIMER_END) begin
            timer_base  <= store_data_i;
            timer_age   <= '0;
            timer_known <= 1'b1;
        end else if (store_address_i < `IO_END) begin
            direct_pending <= 1'b1;
            direct_addr    <= store_address_i;
            direct_data    <= store_data_i;
            direct_width   <= store_width_i;
        end else begin
            exp_addr_q.push_back(store_address_i);
            exp_data_q.push_back(store_data_i);
            exp_width_q.push_back(store_width_i);
        end
    endtask

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with stores still outstanding", cycle_count);
            $display(">>> FAIL");
            $finish;
        end else if (!rst_n_i) begin
            reset_seen <= 1'b1;
        end else begin
            if (timer_known) begin
                timer_age <= timer_age + 32'd1;
            end
            if (mem_req_o && mem_done_i) begin
                check_write();
            end
            // Issue comes last so a timer write overrides the age step
            if (valid_operation_i && idle_o) begin
                record_issue();
            end
        end
    end

    // ==================================================
    // Memory responder
    // ==================================================

    // Done is a single pulse after 1 to 5 cycles, paused while mem_stall is high
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_done_i <= 1'b0;
            wait_count <= 0;
        end else if (mem_done_i) begin
            mem_done_i <= 1'b0;
            wait_count <= 0;
        end else if (mem_req_o && !mem_stall) begin
            if (wait_count + 1 >= mem_delay) begin
                mem_done_i <= 1'b1;
            end else begin
                wait_count <= wait_count + 1;
            end
        end
    end

    // A fresh delay is drawn once per completed write, halfway through the done pulse
    always @(negedge clk_i) begin
        if (mem_done_i) begin
            mem_delay <= 1 + random_word() % 5;
        end
    end

    // ==================================================
    // Protocol assertions
    // ==================================================

    // Second reset cycle onward, plus the first cycle out of reset
    reset_state_a: assert property (@(posedge clk_i)
        reset_seen && (!rst_n_i || $past(!rst_n_i)) |->
            idle_o && !data_valid_o && !illegal_access_o && !mem_req_o)
    else begin
        mismatch_count++;
        $write("MISMATCH idle_o/data_valid_o/illegal_access_o/mem_req_o expected 1/0/0/0");
        $display(" got %h/%h/%h/%h", $sampled(idle_o), $sampled(data_valid_o),
                 $sampled(illegal_access_o), $sampled(mem_req_o));
    end

    illegal_done_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_operation_i && idle_o && store_address_i < `BOOT_END |=>
            data_valid_o && illegal_access_o)
    else begin
        failure_count++;
        $display("Boot store did not complete with illegal_access_o the cycle after issue");
    end

    boot_never_written_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o |-> mem_address_o >= `BOOT_END)
    else begin
        failure_count++;
        $display("Boot address %h appeared on the memory port", $sampled(mem_address_o));
    end

    // A port grab decided while the direct store waited must serve it first
    direct_first_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(mem_req_o) && $past(direct_pending) |-> mem_address_o == direct_addr)
    else begin
        mismatch_count++;
        $display("MISMATCH mem_address_o expected %h got %h", $sampled(direct_addr),
                 $sampled(mem_address_o));
    end

    direct_wait_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        direct_pending |-> !data_valid_o)
    else begin
        failure_count++;
        $display("data_valid_o rose before the direct store was written to memory");
    end

    timer_value_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        timer_known |-> timer_value_o == timer_base + (timer_age >> 1))
    else begin
        mismatch_count++;
        $display("MISMATCH timer_value_o expected %h got %h",
                 $sampled(timer_base + (timer_age >> 1)), $sampled(timer_value_o));
    end

    stall_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_check |-> !idle_o && !data_valid_o)
    else begin
        failure_count++;
        $display("Store completed while memory was stalled and the buffer was full");
    end

    // ==================================================
    // Stimulus
    // ==================================================

    // Called on a rising edge, returns on the edge that took the store
    task automatic start_store(input data_word_t address, input data_word_t data,
                               input store_width_t width);
        valid_operation_i <= 1'b1;
        store_address_i   <= address;
        store_data_i      <= data;
        store_width_i     <= width;
        @(posedge clk_i);
        while (!idle_o) begin
            @(posedge clk_i);
        end
        valid_operation_i <= 1'b0;
    endtask

    task automatic finish_store();
        int unsigned delay;
        while (!data_valid_o) begin
            @(posedge clk_i);
        end
        delay = random_word() % 3;
        repeat (delay) @(posedge clk_i);
        data_accepted_i <= 1'b1;
        @(posedge clk_i);
        data_accepted_i <= 1'b0;
    endtask

    task automatic do_store(input int region);
        start_store(region_address(region), random_word(), store_width_t'(random_word() % 3));
        finish_store();
    endtask

    // Buffer empty and port free, so all credits are back
    task automatic wait_drained();
        while (exp_addr_q.size() != 0 || direct_pending || mem_req_o) begin
            @(posedge clk_i);
        end
    endtask

    initial begin
        int i;
        while (!rst_n_i) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);

        // Plain cachable traffic
        for (i = 0; i < 10; i++) begin
            do_store(3);
        end

        // Entries queue behind a stalled write, then an IO store arrives
        wait_drained();
        mem_stall <= 1'b1;
        for (i = 0; i < 3; i++) begin
            do_store(3);
        end
        fork
            do_store(2);
            begin
                repeat (6) @(posedge clk_i);
                mem_stall <= 1'b0;
            end
        join

        for (i = 0; i < 3; i++) begin
            do_store(0);
        end

        // Idle gaps let the timer count between writes
        for (i = 0; i < 3; i++) begin
            do_store(1);
            repeat (7) @(posedge clk_i);
        end

        // Fill the buffer against a stalled memory, one more store must wait
        wait_drained();
        mem_stall <= 1'b1;
        for (i = 0; i < BUF_DEPTH; i++) begin
            do_store(3);
        end
        start_store(region_address(3), random_word(), STORE_WORD);
        stall_check <= 1'b1;
        repeat (8) @(posedge clk_i);
        stall_check <= 1'b0;
        mem_stall   <= 1'b0;
        finish_store();

        for (i = 0; i < 10; i++) begin
            do_store(int'(random_word() % 4));
        end

        wait_drained();
        repeat (4) @(posedge clk_i);
        $display("Summary: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : store_subsystem_tb

// File: test/tb_clock_gen.sv
/*
 * Clock and synchronous reset for the testbench, reset released on a rising edge.
 */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Reset stays low for a whole number of rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule : tb_clock_gen

// File: rtl/store_subsystem_top.sv
/*
 * Store path of the execution unit with plain ports towards core and memory.
 * BUF_DEPTH sets buffer size and initial credits and must be 2 or more.
 */
`timescale 1ns/1ns

module store_subsystem_top
    import store_pkg::*;
#(
    parameter int BUF_DEPTH = 4
) (
    input  logic         clk_i,
    input  logic         rst_n_i,

    // Store request from the issue stage
    input  logic         valid_operation_i,
    input  data_word_t   store_address_i,
    input  data_word_t   store_data_i,
    input  store_width_t store_width_i,
    input  logic         data_accepted_i,

    // Unit status towards the scheduler
    output logic         idle_o,
    output logic         illegal_access_o,
    output logic         cachable_o,
    output logic         data_valid_o,

    output timer_word_t  timer_value_o,

    // Memory write port
    output logic         mem_req_o,
    output data_word_t   mem_address_o,
    output data_word_t   mem_data_o,
    output store_width_t mem_width_o,
    input  logic         mem_done_i
);

    logic        timer_write;
    timer_word_t timer_data;

    // ==================================================
    // Blocks
    // ==================================================

    store_buffer_if #(
        .BUF_DEPTH (BUF_DEPTH)
    ) sb_if (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i)
    );

    store_unit #(
        .BUF_DEPTH (BUF_DEPTH)
    ) store_unit_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .valid_operation_i (valid_operation_i),
        .store_address_i   (store_address_i),
        .store_data_i      (store_data_i),
        .store_width_i     (store_width_i),
        .data_accepted_i   (data_accepted_i),
        .sb                (sb_if.unit),
        .timer_write_o     (timer_write),
        .timer_data_o      (timer_data),
        .idle_o            (idle_o),
        .illegal_access_o  (illegal_access_o),
        .cachable_o        (cachable_o),
        .data_valid_o      (data_valid_o)
    );

    store_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) store_buffer_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .mem_done_i    (mem_done_i),
        .sb            (sb_if.buffer),
        .mem_req_o     (mem_req_o),
        .mem_address_o (mem_address_o),
        .mem_data_o    (mem_data_o),
        .mem_width_o   (mem_width_o)
    );

    mtime_timer mtime_timer_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .write_i      (timer_write),
        .write_data_i (timer_data),
        .value_o      (timer_value_o)
    );

endmodule : store_subsystem_top

// File: rtl/store_unit.sv
/*
 * Handles one store at a time, taken when valid_operation_i meets idle_o.
 * Cachable stores need a credit and wait in WAIT_BUFFER without one.
 */
`timescale 1ns/1ns
`include "store_memory_map.svh"

module store_unit
    import store_pkg::*;
#(
    parameter int BUF_DEPTH = 4
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          valid_operation_i,
    input  data_word_t    store_address_i,
    input  data_word_t    store_data_i,
    input  store_width_t  store_width_i,
    input  logic          data_accepted_i,
    store_buffer_if.unit  sb,
    output logic          timer_write_o,
    output timer_word_t   timer_data_o,
    output logic          idle_o,
    output logic          illegal_access_o,
    output logic          cachable_o,
    output logic          data_valid_o
);

    localparam int CREDIT_W = $clog2(BUF_DEPTH + 1);

    typedef enum logic [1:0] {IDLE, WAIT_MEMORY, WAIT_BUFFER, WAIT_ACCEPT} state_t;

    state_t              state_q;
    state_t              state_d;

    logic                in_boot;
    logic                in_timer;
    logic                in_cachable;
    logic                issue;
    logic                has_credit;

    data_word_t          address_q;
    data_word_t          data_q;
    store_width_t        width_q;
    logic                cachable_q;
    logic                illegal_q;
    logic [CREDIT_W-1:0] credits_q;

    // ==================================================
    // Address decode
    // ==================================================

    // Decode always looks at the presented address, valid or not
    assign in_boot     = store_address_i < `BOOT_END;
    assign in_timer    = (store_address_i >= `TIMER_START) && (store_address_i < `TIMER_END);
    assign in_cachable = store_address_i >= `IO_END;

    // A store is taken only from IDLE
    assign issue = (state_q == IDLE) && valid_operation_i;

    // Fields are captured at the issue edge so later states see them stable
    always_ff @(posedge clk_i) begin
        if (issue) begin
            address_q  <= store_address_i;
            data_q     <= store_data_i;
            width_q    <= store_width_i;
            cachable_q <= in_cachable;
        end
    end

    // ==================================================
    // Credits
    // ==================================================

    // One credit per free buffer slot, spent on push and paid back per completion
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credits_q <= CREDIT_W'(BUF_DEPTH);
        end else begin
            credits_q <= credits_q - CREDIT_W'(sb.push) + CREDIT_W'(sb.credit_return);
        end
    end

    // A credit returned this cycle only counts from the next one
    assign has_credit = credits_q != '0;

    // ==================================================
    // FSM
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d       = state_q;
        sb.push       = 1'b0;
        timer_write_o = 1'b0;

        case (state_q)
            IDLE: begin
                if (valid_operation_i) begin
                    if (in_boot) begin
                        state_d = WAIT_ACCEPT;
                    end else if (in_timer) begin
                        // The timer loads on the next edge, no wait needed
                        timer_write_o = 1'b1;
                        state_d       = WAIT_ACCEPT;
                    end else if (in_cachable) begin
                        if (has_credit) begin
                            sb.push = 1'b1;
                            state_d = WAIT_ACCEPT;
                        end else begin
                            state_d = WAIT_BUFFER;
                        end
                    end else begin
                        state_d = WAIT_MEMORY;
                    end
                end
            end

            WAIT_MEMORY: begin
                if (sb.direct_done) begin
                    state_d = WAIT_ACCEPT;
                end
            end

            WAIT_BUFFER: begin
                if (has_credit) begin
                    sb.push = 1'b1;
                    state_d = WAIT_ACCEPT;
                end
            end

            WAIT_ACCEPT: begin
                if (data_accepted_i) begin
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // ==================================================
    // Outputs
    // ==================================================

    // Illegal flag is held from issue until the store is accepted
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            illegal_q <= 1'b0;
        end else if (issue && in_boot) begin
            illegal_q <= 1'b1;
        end else if ((state_q == WAIT_ACCEPT) && data_accepted_i) begin
            illegal_q <= 1'b0;
        end
    end

    assign illegal_access_o = (issue && in_boot) || illegal_q;
    assign idle_o           = state_q == IDLE;
    assign data_valid_o     = state_q == WAIT_ACCEPT;
    assign cachable_o       = (state_q == IDLE) ? in_cachable : cachable_q;
    assign timer_data_o     = store_data_i;

    // Push from IDLE uses the live inputs, from WAIT_BUFFER the captured ones
    assign sb.push_address = (state_q == IDLE) ? store_address_i : address_q;
    assign sb.push_data    = (state_q == IDLE) ? store_data_i : data_q;
    assign sb.push_width   = (state_q == IDLE) ? store_width_i : width_q;

    // Direct request holds until done, fields come from the capture registers
    assign sb.direct_req     = state_q == WAIT_MEMORY;
    assign sb.direct_address = address_q;
    assign sb.direct_data    = data_q;
    assign sb.direct_width   = width_q;

    // ==================================================
    // Assertions
    // ==================================================

    credit_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credits_q <= CREDIT_W'(BUF_DEPTH));

    // A boot store is flagged, completes without touching the buffer or memory
    illegal_flag_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue && in_boot |=> illegal_access_o && data_valid_o && !sb.push && !sb.direct_req);

endmodule : store_unit

// File: rtl/store_buffer.sv
/*
 * Queues cachable stores and drains them to the single memory write port.
 * Relies on the unit's credits to never overflow, a direct store wins an idle port.
 */
`timescale 1ns/1ns

module store_buffer
    import store_pkg::*;
#(
    parameter int BUF_DEPTH = 4
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           mem_done_i,
    store_buffer_if.buffer sb,
    output logic           mem_req_o,
    output data_word_t     mem_address_o,
    output data_word_t     mem_data_o,
    output store_width_t   mem_width_o
);

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    data_word_t       address_mem [BUF_DEPTH];
    data_word_t       data_mem    [BUF_DEPTH];
    store_width_t     width_mem   [BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             busy_q;
    logic             owner_direct_q;
    logic             pop;

    // Pointers wrap explicitly so any depth works, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    // ==================================================
    // Queue storage
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (sb.push) begin
            address_mem[wr_ptr_q] <= sb.push_address;
            data_mem[wr_ptr_q]    <= sb.push_data;
            width_mem[wr_ptr_q]   <= sb.push_width;
        end
    end

    // The head leaves the queue only once memory has taken it
    assign pop = busy_q && !owner_direct_q && mem_done_i;

    // ==================================================
    // Pointers and port ownership
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q       <= '0;
            rd_ptr_q       <= '0;
            count_q        <= '0;
            busy_q         <= 1'b0;
            owner_direct_q <= 1'b0;
        end else begin
            if (sb.push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(sb.push) - CNT_W'(pop);

            // Arbitrate only while the port is free so a write is never cut off
            if (busy_q) begin
                if (mem_done_i) begin
                    busy_q <= 1'b0;
                end
            end else if (sb.direct_req) begin
                busy_q         <= 1'b1;
                owner_direct_q <= 1'b1;
            end else if (count_q != '0) begin
                busy_q         <= 1'b1;
                owner_direct_q <= 1'b0;
            end
        end
    end

    // Both sources hold their fields for the whole write
    assign mem_req_o     = busy_q;
    assign mem_address_o = owner_direct_q ? sb.direct_address : address_mem[rd_ptr_q];
    assign mem_data_o    = owner_direct_q ? sb.direct_data : data_mem[rd_ptr_q];
    assign mem_width_o   = owner_direct_q ? sb.direct_width : width_mem[rd_ptr_q];

    // Done is routed to whichever side owns the write
    assign sb.credit_return = pop;
    assign sb.direct_done   = busy_q && owner_direct_q && mem_done_i;

    // ==================================================
    // Assertions
    // ==================================================

    no_overflow_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        sb.push |-> count_q < CNT_W'(BUF_DEPTH));

    // Holds only if the unit keeps the direct fields and no push lands on the head
    port_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o && !mem_done_i |=> mem_req_o && $stable(mem_address_o)
            && $stable(mem_data_o) && $stable(mem_width_o));

endmodule : store_buffer

// File: rtl/mtime_timer.sv
/*
 * Free running timer that advances once every two clock cycles.
 * A write loads the value and restarts the prescaler.
 */
`timescale 1ns/1ns

module mtime_timer
    import store_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        write_i,
    input  timer_word_t write_data_i,
    output timer_word_t value_o
);

    timer_word_t count_q;
    logic        prescale_q;

    // ==================================================
    // Counter
    // ==================================================

    // Prescaler toggles every cycle, the count moves when it is high
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q    <= '0;
            prescale_q <= 1'b0;
        end else if (write_i) begin
            // Cleared prescaler puts the first increment two cycles after the load
            count_q    <= write_data_i;
            prescale_q <= 1'b0;
        end else begin
            prescale_q <= !prescale_q;
            if (prescale_q) begin
                count_q <= count_q + timer_word_t'(1);
            end
        end
    end

    assign value_o = count_q;

endmodule : mtime_timer

// File: rtl/store_buffer_if.sv
/*
 * Link between store unit and store buffer with credit based flow control.
 * The unit owns the credits and the buffer never reports fullness.
 */
`timescale 1ns/1ns

interface store_buffer_if
    import store_pkg::*;
#(
    parameter int BUF_DEPTH = 4
) (
    input logic clk_i,
    input logic rst_n_i
);

    localparam int CREDIT_W = $clog2(BUF_DEPTH + 1);

    // Push channel, one pulse per cachable store
    logic         push;
    data_word_t   push_data;
    data_word_t   push_address;
    store_width_t push_width;

    // One pulse per entry that completed at memory
    logic         credit_return;

    // Direct channel for uncached IO stores
    logic         direct_req;
    data_word_t   direct_data;
    data_word_t   direct_address;
    store_width_t direct_width;
    logic         direct_done;

    // Entries handed over and not yet paid back, seen from the wires
    logic [CREDIT_W-1:0] in_flight_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            in_flight_q <= '0;
        end else begin
            in_flight_q <= in_flight_q + CREDIT_W'(push) - CREDIT_W'(credit_return);
        end
    end

    // The buffer may only pay back credits for entries it actually received
    credit_balance_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_return |-> in_flight_q != '0);

    modport unit (
        output push, push_data, push_address, push_width,
        output direct_req, direct_data, direct_address, direct_width,
        input  credit_return, direct_done
    );

    modport buffer (
        input  push, push_data, push_address, push_width,
        input  direct_req, direct_data, direct_address, direct_width,
        output credit_return, direct_done
    );

endinterface : store_buffer_if

// File: rtl/store_pkg.sv
/*
 * Shared types for the store path.
 * Width codes travel to memory unchanged and are not decoded in this design.
 */
package store_pkg;

    // ==================================================
    // Vector types
    // ==================================================

    // Store address and store data share one word type
    typedef logic [31:0] data_word_t;

    // Access width code as issued by the decoder
    typedef logic [1:0] store_width_t;

    // Value of the memory mapped timer
    typedef logic [31:0] timer_word_t;

    // ==================================================
    // Width codes
    // ==================================================

    // Single byte store
    localparam store_width_t STORE_BYTE = 2'b00;

    // Halfword store, two bytes
    localparam store_width_t STORE_HALF = 2'b01;

    // Full word store, four bytes
    localparam store_width_t STORE_WORD = 2'b10;

    // Code 2'b11 is reserved and never issued

endpackage : store_pkg

// File: include/store_memory_map.svh
/*
 * Store address regions are half-open ranges in byte addresses.
 * The timer window lies inside the IO region and is decoded before it.
 */
`ifndef STORE_MEMORY_MAP_SVH
`define STORE_MEMORY_MAP_SVH

// ==================================================
// Region boundaries
// ==================================================

// Everything below this address is boot memory and cannot be written
`define BOOT_END    32'h0000_1000

// Uncached IO space runs from BOOT_END up to this address
`define IO_END      32'h0000_2000

// Memory mapped timer window, four words wide
`define TIMER_START 32'h0000_1000
`define TIMER_END   32'h0000_1010

`endif
